//--- hw/gfx_fixed_pkg.sv
// fixed-point formats and arithmetic constants, imported by every RTL file of the vertex stage
package gfx_fixed_pkg;

	////////////////////////////////////////
	// number formats
	////////////////////////////////////////

	typedef logic signed [15:0] fix16_t;	// Q8.8 world, matrix, normal, light, clip
	typedef logic signed [15:0] ndc_t;		// Q2.14 normalized coordinate
	typedef logic signed [19:0] scr_t;		// integer pixel and edge value
	typedef logic signed [39:0] prod_t;		// full multiplier product
	typedef logic signed [31:0] quot_t;		// divider operands and quotient

	////////////////////////////////////////
	// arithmetic constants
	////////////////////////////////////////

	localparam int MUL_W = 20;				// multiplier operand width
	localparam int FRAC_BITS = 8;
	localparam int NDC_FRAC_BITS = 14;
	localparam fix16_t FIX_ONE = 16'sd256;	// homogeneous w of every vertex
	localparam int SHADE_W = 3;				// flat shading intensity

endpackage

//--- hw/gfx_screen_pkg.sv
// screen geometry and FSM state encodings, imported by the transform and setup engines
package gfx_screen_pkg;

	// 640x480 viewport, centre doubles as scale
	localparam int SCREEN_HALF_W = 320;
	localparam int SCREEN_HALF_H = 240;

	// vertex_transform phases
	typedef enum logic [2:0] {
		XF_IDLE,
		XF_CLIP,
		XF_DIVIDE,
		XF_VIEWPORT,
		XF_SHADE,
		XF_PUBLISH
	} xform_state_t;

	// triangle_setup phases, one pass of mul_x/mul_y/sum per edge
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL_X,
		ST_MUL_Y,
		ST_SUM
	} setup_state_t;

endpackage

//--- hw/seq_multiplier.sv
// iterative signed shift-add multiplier, one operand bit per cycle, shared through mult_arbiter
`timescale 1ns/100ps

module seq_multiplier (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_valid,
	output logic                 o_ready,
	input  gfx_fixed_pkg::scr_t  i_a,
	input  gfx_fixed_pkg::scr_t  i_b,
	output logic                 o_done,
	output gfx_fixed_pkg::prod_t o_product
);
	import gfx_fixed_pkg::*;

	logic               busy;
	logic [4:0]         count;
	logic               neg;
	logic [MUL_W-1:0]   mag_a;
	logic [MUL_W-1:0]   mag_b;
	logic [2*MUL_W-1:0] mcand;		// shifts left each step
	logic [MUL_W-1:0]   mplier;		// shifts right each step
	logic [2*MUL_W-1:0] acc;
	logic [2*MUL_W-1:0] acc_next;

	assign o_ready = !busy;
	assign mag_a = i_a[MUL_W-1] ? -i_a : i_a;
	assign mag_b = i_b[MUL_W-1] ? -i_b : i_b;
	assign acc_next = mplier[0] ? acc + mcand : acc;

	// done lands MUL_W+1 cycles after acceptance
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			o_done <= 1'b0;
			o_product <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_valid && !busy) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == 5'(MUL_W - 1)) begin
					busy <= 1'b0;
					o_done <= 1'b1;
					o_product <= neg ? -acc_next : acc_next;	// restore sign
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid && !busy) begin
			neg <= i_a[MUL_W-1] ^ i_b[MUL_W-1];
			mcand <= {{MUL_W{1'b0}}, mag_a};
			mplier <= mag_b;
			acc <= '0;
		end else if (busy) begin
			acc <= acc_next;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

//--- hw/seq_divider.sv
// iterative signed restoring divider for the perspective divide, truncating toward zero
`timescale 1ns/100ps

module seq_divider (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_valid,
	output logic                 o_ready,
	input  gfx_fixed_pkg::quot_t i_dividend,
	input  gfx_fixed_pkg::quot_t i_divisor,
	output logic                 o_done,
	output gfx_fixed_pkg::quot_t o_quotient
);
	import gfx_fixed_pkg::*;

	logic        busy;
	logic [4:0]  count;
	logic        neg;
	logic [31:0] mag_n;
	logic [31:0] mag_d;
	logic [31:0] dvs;
	logic [31:0] rem;
	logic [31:0] quo;		// dividend bits shift out, quotient bits shift in
	logic [32:0] rem_shift;
	logic [32:0] diff;
	logic [31:0] quo_next;

	assign o_ready = !busy;
	assign mag_n = i_dividend[31] ? -i_dividend : i_dividend;
	assign mag_d = i_divisor[31] ? -i_divisor : i_divisor;

	// one restoring step
	assign rem_shift = {rem, quo[31]};
	assign diff = rem_shift - {1'b0, dvs};
	assign quo_next = {quo[30:0], !diff[32]};

	// 32 steps, done 33 cycles after acceptance
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			o_done <= 1'b0;
			o_quotient <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_valid && !busy) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == 5'd31) begin
					busy <= 1'b0;
					o_done <= 1'b1;
					if (dvs == '0)
						o_quotient <= '0;		// divide by zero gives zero
					else
						o_quotient <= neg ? -quo_next : quo_next;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid && !busy) begin
			neg <= i_dividend[31] ^ i_divisor[31];
			dvs <= mag_d;
			rem <= '0;
			quo <= mag_n;
		end else if (busy) begin
			rem <= diff[32] ? rem_shift[31:0] : diff[31:0];
			quo <= quo_next;
		end
	end

endmodule

//--- hw/mult_arbiter.sv
// fixed-priority arbiter sharing one multiplier between triangle setup and vertex transform
`timescale 1ns/100ps

module mult_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	// transform client
	input  logic                 i_xf_valid,
	output logic                 o_xf_ready,
	input  gfx_fixed_pkg::scr_t  i_xf_a,
	input  gfx_fixed_pkg::scr_t  i_xf_b,
	output logic                 o_xf_done,
	// setup client, higher priority
	input  logic                 i_st_valid,
	output logic                 o_st_ready,
	input  gfx_fixed_pkg::scr_t  i_st_a,
	input  gfx_fixed_pkg::scr_t  i_st_b,
	output logic                 o_st_done,
	// multiplier side
	output logic                 o_mul_valid,
	input  logic                 i_mul_ready,
	output gfx_fixed_pkg::scr_t  o_mul_a,
	output gfx_fixed_pkg::scr_t  o_mul_b,
	input  logic                 i_mul_done,
	input  gfx_fixed_pkg::prod_t i_mul_product,
	output gfx_fixed_pkg::prod_t o_product
);
	import gfx_fixed_pkg::*;

	logic busy;			// one multiply in flight
	logic owner_st;

	// setup wins whenever it asks
	assign o_mul_valid = !busy && (i_st_valid || i_xf_valid);
	assign o_mul_a = i_st_valid ? i_st_a : i_xf_a;
	assign o_mul_b = i_st_valid ? i_st_b : i_xf_b;
	assign o_st_ready = !busy && i_mul_ready;
	assign o_xf_ready = !busy && i_mul_ready && !i_st_valid;

	// done goes back to the recorded owner only
	assign o_st_done = busy && owner_st && i_mul_done;
	assign o_xf_done = busy && !owner_st && i_mul_done;
	assign o_product = i_mul_product;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner_st <= 1'b0;
		end else if (o_mul_valid && i_mul_ready) begin
			busy <= 1'b1;
			owner_st <= i_st_valid;
		end else if (i_mul_done) begin
			busy <= 1'b0;
		end
	end

endmodule

//--- hw/vertex_transform.sv
// transforms one triangle to screen space and flat shade, publishing it with a one-cycle strobe
`timescale 1ns/100ps

module vertex_transform (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              i_tri_valid,
	output logic                              o_tri_ready,
	input  gfx_fixed_pkg::fix16_t             i_world [0:8],
	input  gfx_fixed_pkg::fix16_t             i_normal [0:2],
	input  gfx_fixed_pkg::fix16_t             i_light [0:2],
	input  gfx_fixed_pkg::fix16_t             i_vp_row0 [0:3],
	input  gfx_fixed_pkg::fix16_t             i_vp_row1 [0:3],
	input  gfx_fixed_pkg::fix16_t             i_vp_row3 [0:3],
	// multiplier client
	output logic                              o_mul_valid,
	input  logic                              i_mul_ready,
	output gfx_fixed_pkg::scr_t               o_mul_a,
	output gfx_fixed_pkg::scr_t               o_mul_b,
	input  logic                              i_mul_done,
	input  gfx_fixed_pkg::prod_t              i_mul_product,
	// divider client
	output logic                              o_div_valid,
	input  logic                              i_div_ready,
	output gfx_fixed_pkg::quot_t              o_dividend,
	output gfx_fixed_pkg::quot_t              o_divisor,
	input  logic                              i_div_done,
	input  gfx_fixed_pkg::quot_t              i_quotient,
	// finished triangle
	output logic                              o_tri_done,
	output gfx_fixed_pkg::scr_t               o_x_scr [0:2],
	output gfx_fixed_pkg::scr_t               o_y_scr [0:2],
	output logic [gfx_fixed_pkg::SHADE_W-1:0] o_shade
);
	import gfx_fixed_pkg::*;
	import gfx_screen_pkg::*;

	xform_state_t state;

	// triangle captured at acceptance
	fix16_t world [0:8];
	fix16_t normal [0:2];
	fix16_t light [0:2];
	fix16_t vp [0:2][0:3];		// matrix rows 0, 1 and 3

	fix16_t clip [0:2][0:2];	// [vertex][x, y, w]
	ndc_t   ndc [0:2][0:1];

	logic [1:0]  vtx;
	logic [1:0]  comp;
	logic [1:0]  term;
	logic [2:0]  div_idx;		// vertex in [2:1], x/y in [0]
	logic        mul_req;
	logic        div_req;
	fix16_t      acc;
	fix16_t      acc_next;
	prod_t       prod_scaled;
	fix16_t      op_a;
	fix16_t      op_b;
	fix16_t      div_num;
	logic [16:0] acc_wide;
	logic [16:0] shade_mag;

	// shift-and-add viewport, ndc * 320 or ndc * 240 plus centre
	function automatic scr_t view_map(ndc_t n, logic is_y);
		logic signed [25:0] ext;
		logic signed [25:0] scaled;
		scr_t offset;
		ext = 26'(n);
		scaled = is_y ? (ext <<< 8) - (ext <<< 4) : (ext <<< 8) + (ext <<< 6);
		offset = is_y ? scr_t'(SCREEN_HALF_H) : scr_t'(SCREEN_HALF_W);
		return offset + scr_t'(scaled >>> NDC_FRAC_BITS);
	endfunction

	assign o_tri_ready = (state == XF_IDLE);
	assign o_tri_done = (state == XF_PUBLISH);
	assign o_mul_valid = mul_req;
	assign o_div_valid = div_req;

	// dot product terms, w always multiplies FIX_ONE
	always_comb begin
		if (state == XF_SHADE) begin
			op_a = normal[term];
			op_b = light[term];
		end else begin
			op_a = (term == 2'd3) ? FIX_ONE : world[vtx * 3 + term];
			op_b = vp[comp][term];
		end
	end

	assign o_mul_a = scr_t'(op_a);
	assign o_mul_b = scr_t'(op_b);
	assign prod_scaled = i_mul_product >>> FRAC_BITS;
	assign acc_next = acc + prod_scaled[15:0];	// wraps to 16 bits

	// clip << 14 over w gives Q2.14
	assign div_num = clip[div_idx[2:1]][div_idx[0]];
	assign o_dividend = {{2{div_num[15]}}, div_num, {NDC_FRAC_BITS{1'b0}}};
	assign o_divisor = quot_t'(clip[div_idx[2:1]][2]);

	assign acc_wide = {acc_next[15], acc_next};
	assign shade_mag = acc_next[15] ? -acc_wide : acc_wide;

	////////////////////////////////////////
	// phase sequencing
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= XF_IDLE;
			mul_req <= 1'b0;
			div_req <= 1'b0;
			vtx <= '0;
			comp <= '0;
			term <= '0;
			div_idx <= '0;
			acc <= '0;
		end else begin
			if (o_mul_valid && i_mul_ready)
				mul_req <= 1'b0;
			if (o_div_valid && i_div_ready)
				div_req <= 1'b0;
			case (state)
				XF_IDLE: begin
					if (i_tri_valid) begin
						vtx <= '0;
						comp <= '0;
						term <= '0;
						acc <= '0;
						mul_req <= 1'b1;
						state <= XF_CLIP;
					end
				end
				XF_CLIP: begin
					if (i_mul_done) begin
						term <= term + 1'b1;		// wraps after the w term
						acc <= acc_next;
						mul_req <= 1'b1;
						if (term == 2'd3) begin
							acc <= '0;
							if (comp == 2'd2) begin
								comp <= '0;
								vtx <= vtx + 1'b1;
								if (vtx == 2'd2) begin
									mul_req <= 1'b0;
									div_req <= 1'b1;
									div_idx <= '0;
									state <= XF_DIVIDE;
								end
							end else begin
								comp <= comp + 1'b1;
							end
						end
					end
				end
				XF_DIVIDE: begin
					if (i_div_done) begin
						div_idx <= div_idx + 1'b1;
						if (div_idx == 3'd5)
							state <= XF_VIEWPORT;
						else
							div_req <= 1'b1;
					end
				end
				XF_VIEWPORT: begin
					term <= '0;
					acc <= '0;
					mul_req <= 1'b1;
					state <= XF_SHADE;
				end
				XF_SHADE: begin
					// normal . light over three terms
					if (i_mul_done) begin
						term <= term + 1'b1;
						acc <= acc_next;
						if (term == 2'd2)
							state <= XF_PUBLISH;
						else
							mul_req <= 1'b1;
					end
				end
				XF_PUBLISH: state <= XF_IDLE;
				default: state <= XF_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// captured operands and results
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == XF_IDLE && i_tri_valid) begin
			world <= i_world;
			normal <= i_normal;
			light <= i_light;
			vp[0] <= i_vp_row0;
			vp[1] <= i_vp_row1;
			vp[2] <= i_vp_row3;
		end
		if (state == XF_CLIP && i_mul_done && term == 2'd3)
			clip[vtx][comp] <= acc_next;
		if (state == XF_DIVIDE && i_div_done)
			ndc[div_idx[2:1]][div_idx[0]] <= i_quotient[15:0];
		if (state == XF_VIEWPORT) begin
			for (int k = 0; k < 3; k++) begin
				o_x_scr[k] <= view_map(ndc[k][0], 1'b0);
				o_y_scr[k] <= view_map(ndc[k][1], 1'b1);
			end
		end
		// |n.l| saturates at 255, top three bits
		if (state == XF_SHADE && i_mul_done && term == 2'd2)
			o_shade <= (shade_mag > 17'd255) ? {SHADE_W{1'b1}} : shade_mag[7:5];
	end

endmodule

//--- hw/triangle_setup.sv
// pending and front triangle store with per-frame edge setup and per-line edge stepping
`timescale 1ns/100ps

module triangle_setup (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              i_tri_done,
	input  gfx_fixed_pkg::scr_t               i_x_scr [0:2],
	input  gfx_fixed_pkg::scr_t               i_y_scr [0:2],
	input  logic [gfx_fixed_pkg::SHADE_W-1:0] i_shade,
	input  logic                              i_frame_start,
	input  logic                              i_line_end,
	// multiplier client
	output logic                              o_mul_valid,
	input  logic                              i_mul_ready,
	output gfx_fixed_pkg::scr_t               o_mul_a,
	output gfx_fixed_pkg::scr_t               o_mul_b,
	input  logic                              i_mul_done,
	input  gfx_fixed_pkg::prod_t              i_mul_product,
	// raster side
	output gfx_fixed_pkg::scr_t               o_y_screen [0:2],
	output gfx_fixed_pkg::scr_t               o_e_init [0:2],
	output logic [gfx_fixed_pkg::SHADE_W-1:0] o_tri_color,
	output logic                              o_setup_done
);
	import gfx_fixed_pkg::*;
	import gfx_screen_pkg::*;

	setup_state_t state;

	// newest finished triangle, waits for frame start
	scr_t               pend_x [0:2];
	scr_t               pend_y [0:2];
	logic [SHADE_W-1:0] pend_shade;
	logic               pend_valid;

	scr_t       front_x [0:2];
	scr_t       step [0:2];		// b-term of each edge
	scr_t       prod_x;
	scr_t       prod_y;
	logic [1:0] edge_idx;
	logic [1:0] edge_nxt;
	logic       mul_req;
	logic       lines_ok;		// edges final for this frame

	assign edge_nxt = (edge_idx == 2'd2) ? 2'd0 : edge_idx + 1'b1;

	always_comb begin
		for (int i = 0; i < 3; i++)
			step[i] = front_x[(i + 1) % 3] - front_x[i];
	end

	// e_k = x_k * (y_k - y_k+1) + y_k * (x_k+1 - x_k)
	assign o_mul_valid = mul_req;
	assign o_mul_a = (state == ST_MUL_Y) ? o_y_screen[edge_idx] : front_x[edge_idx];
	assign o_mul_b = (state == ST_MUL_Y) ? step[edge_idx]
		: o_y_screen[edge_idx] - o_y_screen[edge_nxt];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			mul_req <= 1'b0;
			lines_ok <= 1'b0;
			pend_valid <= 1'b0;
			edge_idx <= '0;
			o_setup_done <= 1'b0;
			o_tri_color <= '0;
			for (int i = 0; i < 3; i++) begin
				front_x[i] <= '0;
				o_y_screen[i] <= '0;
				o_e_init[i] <= '0;
			end
		end else begin
			o_setup_done <= 1'b0;
			if (o_mul_valid && i_mul_ready)
				mul_req <= 1'b0;
			if (i_frame_start) begin
				if (pend_valid) begin
					front_x <= pend_x;
					o_y_screen <= pend_y;
					o_tri_color <= pend_shade;
					pend_valid <= 1'b0;
				end
				edge_idx <= '0;
				lines_ok <= 1'b0;
				mul_req <= 1'b1;
				state <= ST_MUL_X;
			end else begin
				case (state)
					ST_IDLE: begin
						if (i_line_end && lines_ok) begin
							for (int i = 0; i < 3; i++)
								o_e_init[i] <= o_e_init[i] - step[i];
						end
					end
					ST_MUL_X: begin
						if (i_mul_done) begin
							mul_req <= 1'b1;
							state <= ST_MUL_Y;
						end
					end
					ST_MUL_Y: begin
						if (i_mul_done)
							state <= ST_SUM;
					end
					ST_SUM: begin
						o_e_init[edge_idx] <= prod_x + prod_y;	// wraps to 20 bits
						if (edge_idx == 2'd2) begin
							o_setup_done <= 1'b1;
							lines_ok <= 1'b1;
							state <= ST_IDLE;
						end else begin
							edge_idx <= edge_idx + 1'b1;
							mul_req <= 1'b1;
							state <= ST_MUL_X;
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
			if (i_tri_done)
				pend_valid <= 1'b1;		// newest triangle wins
		end
	end

	always_ff @(posedge clk) begin
		if (i_tri_done) begin
			pend_x <= i_x_scr;
			pend_y <= i_y_scr;
			pend_shade <= i_shade;
		end
		if (i_mul_done && state == ST_MUL_X)
			prod_x <= i_mul_product[MUL_W-1:0];
		if (i_mul_done && state == ST_MUL_Y)
			prod_y <= i_mul_product[MUL_W-1:0];
	end

endmodule

//--- hw/vertex_shader.sv
// vertex stage top level, joins both engines, the multiplier arbiter, multiplier and divider
`timescale 1ns/100ps

module vertex_shader (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              i_tri_valid,
	output logic                              o_tri_ready,
	input  gfx_fixed_pkg::fix16_t             i_world [0:8],
	input  gfx_fixed_pkg::fix16_t             i_normal [0:2],
	input  gfx_fixed_pkg::fix16_t             i_light [0:2],
	input  gfx_fixed_pkg::fix16_t             i_vp_row0 [0:3],
	input  gfx_fixed_pkg::fix16_t             i_vp_row1 [0:3],
	input  gfx_fixed_pkg::fix16_t             i_vp_row3 [0:3],
	input  logic                              i_frame_start,
	input  logic                              i_line_end,
	output gfx_fixed_pkg::scr_t               o_y_screen [0:2],
	output gfx_fixed_pkg::scr_t               o_e_init [0:2],
	output logic [gfx_fixed_pkg::SHADE_W-1:0] o_tri_color,
	output logic                              o_setup_done
);
	import gfx_fixed_pkg::*;

	// transform client of the arbiter
	logic xf_mul_valid;
	logic xf_mul_ready;
	scr_t xf_mul_a;
	scr_t xf_mul_b;
	logic xf_mul_done;

	// setup client of the arbiter
	logic st_mul_valid;
	logic st_mul_ready;
	scr_t st_mul_a;
	scr_t st_mul_b;
	logic st_mul_done;

	// arbiter to multiplier
	logic  mul_valid;
	logic  mul_ready;
	scr_t  mul_a;
	scr_t  mul_b;
	logic  mul_done;
	prod_t mul_product;
	prod_t arb_product;		// shared, qualified by each done

	logic  div_valid;
	logic  div_ready;
	quot_t dividend;
	quot_t divisor;
	logic  div_done;
	quot_t quotient;

	// finished triangle toward setup
	logic               tri_done;
	scr_t               x_scr [0:2];
	scr_t               y_scr [0:2];
	logic [SHADE_W-1:0] shade;

	vertex_transform u_transform (
		.clk(clk), .reset(reset),
		.i_tri_valid(i_tri_valid), .o_tri_ready(o_tri_ready),
		.i_world(i_world), .i_normal(i_normal), .i_light(i_light),
		.i_vp_row0(i_vp_row0), .i_vp_row1(i_vp_row1), .i_vp_row3(i_vp_row3),
		.o_mul_valid(xf_mul_valid), .i_mul_ready(xf_mul_ready),
		.o_mul_a(xf_mul_a), .o_mul_b(xf_mul_b),
		.i_mul_done(xf_mul_done), .i_mul_product(arb_product),
		.o_div_valid(div_valid), .i_div_ready(div_ready),
		.o_dividend(dividend), .o_divisor(divisor),
		.i_div_done(div_done), .i_quotient(quotient),
		.o_tri_done(tri_done), .o_x_scr(x_scr), .o_y_scr(y_scr), .o_shade(shade)
	);

	triangle_setup u_setup (
		.clk(clk), .reset(reset),
		.i_tri_done(tri_done), .i_x_scr(x_scr), .i_y_scr(y_scr), .i_shade(shade),
		.i_frame_start(i_frame_start), .i_line_end(i_line_end),
		.o_mul_valid(st_mul_valid), .i_mul_ready(st_mul_ready),
		.o_mul_a(st_mul_a), .o_mul_b(st_mul_b),
		.i_mul_done(st_mul_done), .i_mul_product(arb_product),
		.o_y_screen(o_y_screen), .o_e_init(o_e_init),
		.o_tri_color(o_tri_color), .o_setup_done(o_setup_done)
	);

	mult_arbiter u_arbiter (
		.clk(clk), .reset(reset),
		.i_xf_valid(xf_mul_valid), .o_xf_ready(xf_mul_ready),
		.i_xf_a(xf_mul_a), .i_xf_b(xf_mul_b), .o_xf_done(xf_mul_done),
		.i_st_valid(st_mul_valid), .o_st_ready(st_mul_ready),
		.i_st_a(st_mul_a), .i_st_b(st_mul_b), .o_st_done(st_mul_done),
		.o_mul_valid(mul_valid), .i_mul_ready(mul_ready),
		.o_mul_a(mul_a), .o_mul_b(mul_b),
		.i_mul_done(mul_done), .i_mul_product(mul_product),
		.o_product(arb_product)
	);

	seq_multiplier u_multiplier (
		.clk(clk), .reset(reset),
		.i_valid(mul_valid), .o_ready(mul_ready),
		.i_a(mul_a), .i_b(mul_b),
		.o_done(mul_done), .o_product(mul_product)
	);

	seq_divider u_divider (
		.clk(clk), .reset(reset),
		.i_valid(div_valid), .o_ready(div_ready),
		.i_dividend(dividend), .i_divisor(divisor),
		.o_done(div_done), .o_quotient(quotient)
	);

endmodule

//--- testbench/tb_vertex_shader.sv
// directed testbench for the vertex stage, checks screen y, shade and edge values against a model
`timescale 1ns/100ps

module tb_vertex_shader;
	import gfx_fixed_pkg::*;
	import gfx_screen_pkg::*;

	localparam int WAIT_LIMIT = 5000;	// cycles, longest wait is one full transform

	logic               clk;
	logic               reset;
	logic               i_tri_valid;
	logic               o_tri_ready;
	fix16_t             i_world [0:8];
	fix16_t             i_normal [0:2];
	fix16_t             i_light [0:2];
	fix16_t             i_vp_row0 [0:3];
	fix16_t             i_vp_row1 [0:3];
	fix16_t             i_vp_row3 [0:3];
	logic               i_frame_start;
	logic               i_line_end;
	scr_t               o_y_screen [0:2];
	scr_t               o_e_init [0:2];
	logic [SHADE_W-1:0] o_tri_color;
	logic               o_setup_done;

	// expected pending and front triangle
	scr_t               model_pend_x [0:2];
	scr_t               model_pend_y [0:2];
	logic [SHADE_W-1:0] model_pend_shade;
	logic               model_pend_valid;
	scr_t               model_front_x [0:2];
	scr_t               model_front_y [0:2];
	logic [SHADE_W-1:0] model_front_shade;
	scr_t               model_edge [0:2];
	scr_t               model_step [0:2];

	vertex_shader uut (
		.clk(clk), .reset(reset),
		.i_tri_valid(i_tri_valid), .o_tri_ready(o_tri_ready),
		.i_world(i_world), .i_normal(i_normal), .i_light(i_light),
		.i_vp_row0(i_vp_row0), .i_vp_row1(i_vp_row1), .i_vp_row3(i_vp_row3),
		.i_frame_start(i_frame_start), .i_line_end(i_line_end),
		.o_y_screen(o_y_screen), .o_e_init(o_e_init),
		.o_tri_color(o_tri_color), .o_setup_done(o_setup_done)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// one Q8.8 term added to a 16-bit wrapping sum
	function automatic fix16_t mac_q88(fix16_t acc, fix16_t a, fix16_t b);
		longint p;
		fix16_t t;
		p = longint'(a) * longint'(b);
		t = fix16_t'(p >>> 8);
		return acc + t;
	endfunction

	function automatic fix16_t row_elem(int c, int t);
		case (c)
			0: return i_vp_row0[t];
			1: return i_vp_row1[t];
			default: return i_vp_row3[t];
		endcase
	endfunction

	function automatic ndc_t ndc_of(fix16_t c, fix16_t w);
		longint n;
		if (w == 0)
			return '0;
		n = (longint'(c) * 16384) / longint'(w);	// truncates toward zero
		return ndc_t'(n);
	endfunction

	function automatic scr_t screen_of(ndc_t n, int half);
		longint s;
		s = (longint'(n) * half) >>> NDC_FRAC_BITS;	// floor
		return scr_t'(half + s);
	endfunction

	function automatic logic [SHADE_W-1:0] shade_of(fix16_t d);
		int m;
		m = (d < 0) ? -int'(d) : int'(d);
		if (m > 255)
			m = 255;
		return SHADE_W'(m >>> 5);
	endfunction

	function automatic scr_t edge_of(scr_t xk, scr_t yk, scr_t xn, scr_t yn);
		longint e;
		e = longint'(xk) * (longint'(yk) - longint'(yn))
			+ longint'(yk) * (longint'(xn) - longint'(xk));
		return scr_t'(e);
	endfunction

	// expected result of the triangle now on the inputs
	task model_transform;
		fix16_t clip_v [0:2];
		fix16_t d;
		for (int v = 0; v < 3; v++) begin
			for (int c = 0; c < 3; c++) begin
				d = '0;
				for (int t = 0; t < 3; t++)
					d = mac_q88(d, i_world[v * 3 + t], row_elem(c, t));
				clip_v[c] = mac_q88(d, FIX_ONE, row_elem(c, 3));
			end
			model_pend_x[v] = screen_of(ndc_of(clip_v[0], clip_v[2]), SCREEN_HALF_W);
			model_pend_y[v] = screen_of(ndc_of(clip_v[1], clip_v[2]), SCREEN_HALF_H);
		end
		d = '0;
		for (int t = 0; t < 3; t++)
			d = mac_q88(d, i_normal[t], i_light[t]);
		model_pend_shade = shade_of(d);
		model_pend_valid = 1'b1;
	endtask

	////////////////////////////////////////
	// checks and stimulus helpers
	////////////////////////////////////////

	task check_value(input string what, input longint got, input longint expected);
		if (got !== expected) begin
			$display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			$display("sim failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task stop_on_timeout(input string what);
		$display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
		$display("sim failed");
		$fatal(1, "stopping on timeout");
	endtask

	task next_cycle;
		@(posedge clk);
		#1;
	endtask

	task wait_tri_ready;
		int n;
		n = 0;
		while (!o_tri_ready && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!o_tri_ready)
			stop_on_timeout("o_tri_ready");
	endtask

	task submit_triangle;
		wait_tri_ready();
		i_tri_valid = 1'b1;
		next_cycle();
		i_tri_valid = 1'b0;
		check_value("o_tri_ready in transform", o_tri_ready, 0);
		wait_tri_ready();		// pending is written as ready returns
		model_transform();
	endtask

	task start_frame;
		i_frame_start = 1'b1;
		next_cycle();
		i_frame_start = 1'b0;
		if (model_pend_valid) begin
			model_front_x = model_pend_x;
			model_front_y = model_pend_y;
			model_front_shade = model_pend_shade;
			model_pend_valid = 1'b0;
		end
		for (int k = 0; k < 3; k++) begin
			model_edge[k] = edge_of(model_front_x[k], model_front_y[k],
				model_front_x[(k + 1) % 3], model_front_y[(k + 1) % 3]);
			model_step[k] = model_front_x[(k + 1) % 3] - model_front_x[k];
		end
	endtask

	task check_front;
		for (int k = 0; k < 3; k++) begin
			check_value($sformatf("o_y_screen[%0d]", k), o_y_screen[k], model_front_y[k]);
			check_value($sformatf("o_e_init[%0d]", k), o_e_init[k], model_edge[k]);
		end
		check_value("o_tri_color", o_tri_color, model_front_shade);
	endtask

	task finish_frame;
		int n;
		n = 0;
		while (!o_setup_done && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!o_setup_done)
			stop_on_timeout("o_setup_done after frame start");
		check_front();
	endtask

	task pulse_line_end(input bit counts);
		i_line_end = 1'b1;
		next_cycle();
		i_line_end = 1'b0;
		if (counts) begin
			for (int k = 0; k < 3; k++)
				model_edge[k] = model_edge[k] - model_step[k];
		end
		next_cycle();
	endtask

	task set_identity_matrix;
		i_vp_row0 = '{256, 0, 0, 0};
		i_vp_row1 = '{0, 256, 0, 0};
		i_vp_row3 = '{0, 0, 0, 256};
	endtask

	function automatic fix16_t rand_fix(int lo, int hi);
		return fix16_t'(lo + int'($urandom_range(hi - lo)));
	endfunction

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task test_reset_state;
		check_value("o_tri_ready", o_tri_ready, 1);
		check_value("o_tri_color", o_tri_color, 0);
		for (int k = 0; k < 3; k++) begin
			check_value($sformatf("o_y_screen[%0d]", k), o_y_screen[k], 0);
			check_value($sformatf("o_e_init[%0d]", k), o_e_init[k], 0);
		end
		repeat (50) begin
			check_value("o_setup_done", o_setup_done, 0);
			next_cycle();
		end
	endtask

	task test_identity;
		set_identity_matrix();
		i_world = '{0, 128, 0, -128, -128, 0, 128, -128, 0};	// 0.5 and -0.5
		i_normal = '{0, 0, 256};
		i_light = '{0, 0, 128};
		submit_triangle();
		start_frame();
		finish_frame();
	endtask

	task test_back_facing;
		i_normal = '{0, 0, -96};		// n.l of -0.375
		i_light = '{0, 0, 256};
		submit_triangle();
		start_frame();
		finish_frame();
		i_normal = '{0, 0, -256};		// exactly -1.0
		submit_triangle();
		start_frame();
		finish_frame();
		check_value("o_tri_color at |n.l| 1.0", o_tri_color, 7);
	endtask

	task test_line_steps;
		start_frame();
		pulse_line_end(1'b0);		// before setup finishes
		finish_frame();
		repeat (3)
			pulse_line_end(1'b1);
		check_front();
	endtask

	task test_newest_wins;
		i_world = '{-64, 32, 0, 200, 16, 0, 40, -220, 0};
		submit_triangle();
		i_world = '{96, -48, 0, -150, 100, 0, 10, 180, 0};
		i_normal = '{128, 64, 0};
		submit_triangle();
		start_frame();
		finish_frame();
		start_frame();		// nothing pending
		finish_frame();
	endtask

	task test_random;
		for (int i = 0; i < 10; i++) begin
			for (int j = 0; j < 9; j++)
				i_world[j] = rand_fix(-320, 320);
			i_vp_row0 = '{256, 0, rand_fix(-64, 64), 0};
			i_vp_row1 = '{0, 256, rand_fix(-64, 64), 0};
			i_vp_row3 = '{0, 0, 0, rand_fix(256, 640)};	// w stays positive
			for (int j = 0; j < 3; j++) begin
				i_normal[j] = rand_fix(-512, 512);
				i_light[j] = rand_fix(-512, 512);
			end
			submit_triangle();
			start_frame();
			finish_frame();
		end
	endtask

	initial begin
		void'($urandom(17614));
		clk = 1'b0;
		reset = 1'b1;
		i_tri_valid = 1'b0;
		i_frame_start = 1'b0;
		i_line_end = 1'b0;
		i_world = '{default: '0};
		i_normal = '{default: '0};
		i_light = '{default: '0};
		i_vp_row0 = '{default: '0};
		i_vp_row1 = '{default: '0};
		i_vp_row3 = '{default: '0};
		model_pend_valid = 1'b0;
		model_front_x = '{default: '0};
		model_front_y = '{default: '0};
		model_front_shade = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset_state();
		test_identity();
		test_back_facing();
		test_line_steps();
		test_newest_wins();
		test_random();

		$display("sim passed");
		$finish;
	end

endmodule

//--- tb_vertex_shader.f
hw/gfx_fixed_pkg.sv
hw/gfx_screen_pkg.sv
hw/seq_multiplier.sv
hw/seq_divider.sv
hw/mult_arbiter.sv
hw/vertex_transform.sv
hw/triangle_setup.sv
hw/vertex_shader.sv
testbench/tb_vertex_shader.sv
